// File: rtl/Config.sv
package Config;

    // --------------------------------------------------
    // Core options
    // --------------------------------------------------

    // Enables the RVC expander in the fetch stage
    localparam logic RV_EXT_C = 1'b1;

    // --------------------------------------------------
    // Memory geometry
    // --------------------------------------------------

    localparam int ADDR_WIDTH = 32;       // Byte address width

    localparam int MEM_WORDS = 256;       // Unified memory depth in words

    // Word index taken from the address bits above the byte offset
    localparam int MEM_INDEX_WIDTH = $clog2(MEM_WORDS);

endpackage

// File: rtl/CoreMemSubsystem.sv
module CoreMemSubsystem
    import Types::*;
(
    input  logic    i_clock,
    input  logic    i_rstN,

    // Fetch side
    input  InstAddr i_pcNext,
    output logic    o_hazard,
    output Inst     o_inst,
    output logic    o_instCompressed,
    output logic    o_instValid,
    output InstAddr o_pc,

    // Memory stage side
    input  logic    i_memValid,
    input  logic    i_memRdEnable,
    input  logic    i_memWrEnable,
    input  MemSize  i_memSize,
    input  logic    i_memUnsigned,
    input  DataAddr i_memAddr,
    input  Data     i_memWrData,
    output Data     o_memRdData,
    output logic    o_memRdValid);

    InstMemoryBus instBus ();               // Fetch to arbiter
    DataMemoryBus dataBus ();               // Data unit to arbiter
    MemPortBus    memPort ();               // Arbiter to memory

    // --------------------------------------------------
    // Clients
    // --------------------------------------------------

    StageIF stageIF (
        .i_clock          (i_clock),
        .i_rstN           (i_rstN),
        .instBus          (instBus),
        .i_pcNext         (i_pcNext),
        .o_hazard         (o_hazard),
        .o_inst           (o_inst),
        .o_instCompressed (o_instCompressed),
        .o_instValid      (o_instValid),
        .o_pc             (o_pc));

    DataAccessUnit dataAccess (
        .i_clock       (i_clock),
        .i_rstN        (i_rstN),
        .dataBus       (dataBus),
        .i_memValid    (i_memValid),
        .i_memRdEnable (i_memRdEnable),
        .i_memWrEnable (i_memWrEnable),
        .i_memSize     (i_memSize),
        .i_memUnsigned (i_memUnsigned),
        .i_memAddr     (i_memAddr),
        .i_memWrData   (i_memWrData),
        .o_memRdData   (o_memRdData),
        .o_memRdValid  (o_memRdValid));

    // --------------------------------------------------
    // Shared port
    // --------------------------------------------------

    MemArbiter arbiter (
        .instBus (instBus),
        .dataBus (dataBus),
        .memPort (memPort));

    UnifiedMemory memory (
        .i_clock (i_clock),
        .memPort (memPort));

endmodule

// File: rtl/DataAccessUnit.sv
module DataAccessUnit
    import Types::*;
(
    input  logic    i_clock,
    input  logic    i_rstN,

    DataMemoryBus.master dataBus,           // Data port towards the arbiter

    input  logic    i_memValid,             // MEM stage holds a valid op
    input  logic    i_memRdEnable,          // Load
    input  logic    i_memWrEnable,          // Store
    input  MemSize  i_memSize,
    input  logic    i_memUnsigned,          // Zero extend loads
    input  DataAddr i_memAddr,              // Naturally aligned address
    input  Data     i_memWrData,            // Store value, low aligned
    output Data     o_memRdData,            // Extended load result
    output logic    o_memRdValid);          // One cycle after the load

    Data shifted;                           // Loaded lanes moved to bit 0
    Data loadData;

    // --------------------------------------------------
    // Request side
    // --------------------------------------------------

    assign dataBus.addr = i_memAddr;
    assign dataBus.rd   = i_memValid & i_memRdEnable;
    assign dataBus.wr   = i_memValid & i_memWrEnable;

    // Byte enables from size and offset, data copied into every lane
    always_comb begin
        case (i_memSize)
            BYTE: begin
                dataBus.byteEn = 4'b0001 << i_memAddr[1:0];
                dataBus.wrData = {4{i_memWrData[7:0]}};
            end
            HALF: begin
                dataBus.byteEn = 4'b0011 << {i_memAddr[1], 1'b0};
                dataBus.wrData = {2{i_memWrData[15:0]}};
            end
            default: begin                  // WORD
                dataBus.byteEn = 4'b1111;
                dataBus.wrData = i_memWrData;
            end
        endcase
    end

    // --------------------------------------------------
    // Load alignment and extension
    // --------------------------------------------------

    assign shifted = dataBus.rdData >> {i_memAddr[1:0], 3'b000};

    always_comb begin
        case (i_memSize)
            BYTE:    loadData = {{24{~i_memUnsigned & shifted[7]}}, shifted[7:0]};
            HALF:    loadData = {{16{~i_memUnsigned & shifted[15]}}, shifted[15:0]};
            default: loadData = shifted;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rstN)
            o_memRdValid <= 1'b0;
        else
            o_memRdValid <= dataBus.rd;     // Single-cycle pulse per load
    end

    always_ff @(posedge i_clock) begin
        if (dataBus.rd)
            o_memRdData <= loadData;
    end

endmodule

// File: rtl/DataMemoryBus.sv
interface DataMemoryBus
    import Types::*;
();

    DataAddr   addr;    // Load/store address
    logic      rd;      // Load request
    logic      wr;      // Store request
    ByteEnable byteEn;  // Lanes written by a store
    Data       wrData;  // Store data, already in its lanes
    Data       rdData;  // Raw word at addr

    // Data access unit side
    modport master (
        output addr, rd, wr, byteEn, wrData,
        input  rdData);

    // Arbiter side
    modport slave (
        input  addr, rd, wr, byteEn, wrData,
        output rdData);

endinterface

// File: rtl/InstExpander.sv
module InstExpander
    import Types::*;
(
    input  InstWord i_inst,          // Word read from memory
    input  logic    i_upperHalf,     // Parcel at pc offset 2
    output Inst     o_inst,          // RV32I instruction
    output logic    o_isCompressed); // Parcel was an RVC form

    logic [15:0] c;       // Selected parcel
    logic [4:0]  rd;      // Full register fields
    logic [4:0]  rs2;
    logic [4:0]  rdP;     // Compressed register fields, x8..x15
    logic [4:0]  rs1P;
    logic [6:0]  lwImm;   // C.LW/C.SW word offset
    logic [20:0] jOff;    // C.J offset, sign extended
    logic [12:0] bOff;    // C.BEQZ offset, sign extended
    logic [11:0] ciImm;   // C.ADDI/C.LI immediate

    assign c = i_upperHalf ? i_inst.parcels.high : i_inst.parcels.low;

    // Low two bits 11 mark a 32-bit instruction
    assign o_isCompressed = (c[1:0] != 2'b11);

    // --------------------------------------------------
    // Fields and immediates
    // --------------------------------------------------

    assign rd   = c[11:7];
    assign rs2  = c[6:2];
    assign rdP  = {2'b01, c[4:2]};
    assign rs1P = {2'b01, c[9:7]};

    assign lwImm = {c[5], c[12:10], c[6], 2'b00};        // uimm[6:2]
    assign ciImm = {{6{c[12]}}, c[12], c[6:2]};          // imm[5:0]

    // offset[11|4|9:8|10|6|7|3:1|5]
    assign jOff = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};

    // offset[8|4:3] and offset[7:6|2:1|5]
    assign bOff = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};

    // --------------------------------------------------
    // Mapping by quadrant and funct3
    // --------------------------------------------------

    always_comb begin
        o_inst = '0;                                     // Illegal unless matched
        if (!o_isCompressed)
            o_inst = i_inst.inst;
        else begin
            case ({c[15:13], c[1:0]})
                5'b010_00:                               // C.LW -> lw
                    o_inst = {5'b0, lwImm, rs1P, 3'b010, rdP, 7'b0000011};
                5'b110_00:                               // C.SW -> sw
                    o_inst = {5'b0, lwImm[6:5], rdP, rs1P, 3'b010,
                              lwImm[4:0], 7'b0100011};
                5'b000_01:                               // C.ADDI and C.NOP
                    o_inst = {ciImm, rd, 3'b000, rd, 7'b0010011};
                5'b010_01:                               // C.LI -> addi rd, x0
                    o_inst = {ciImm, 5'd0, 3'b000, rd, 7'b0010011};
                5'b101_01:                               // C.J -> jal x0
                    o_inst = {jOff[20], jOff[10:1], jOff[11], jOff[19:12],
                              5'd0, 7'b1101111};
                5'b110_01:                               // C.BEQZ -> beq rs1', x0
                    o_inst = {bOff[12], bOff[10:5], 5'd0, rs1P, 3'b000,
                              bOff[4:1], bOff[11], 7'b1100011};
                5'b100_10: begin
                    // rs2 of zero is C.JR/C.JALR/C.EBREAK, left illegal here
                    if (rs2 != 5'd0) begin
                        if (!c[12])                      // C.MV -> add rd, x0, rs2
                            o_inst = {7'b0, rs2, 5'd0, 3'b000, rd, 7'b0110011};
                        else                             // C.ADD -> add rd, rd, rs2
                            o_inst = {7'b0, rs2, rd, 3'b000, rd, 7'b0110011};
                    end
                end
                default:
                    o_inst = '0;                         // Unsupported RVC form
            endcase
        end
    end

endmodule

// File: rtl/InstMemoryBus.sv
interface InstMemoryBus
    import Types::*;
();

    InstAddr addr;  // Fetch address
    logic    rd;    // Fetch request
    Inst     inst;  // Word read at addr
    logic    busy;  // Port taken, inst not valid this cycle

    // Fetch stage side
    modport master (
        output addr, rd,
        input  inst, busy);

    // Arbiter side
    modport slave (
        input  addr, rd,
        output inst, busy);

endinterface

// File: rtl/MemArbiter.sv
module MemArbiter (
    InstMemoryBus.slave  instBus,           // Fetch stage
    DataMemoryBus.slave  dataBus,           // Data access unit
    MemPortBus.master    memPort);          // Unified memory

    logic dataGrant;                        // Data owns the port this cycle

    // --------------------------------------------------
    // Fixed priority, data over fetch
    // --------------------------------------------------

    assign dataGrant = dataBus.rd | dataBus.wr;

    assign memPort.addr = dataGrant ? dataBus.addr : instBus.addr;

    // Only data ever writes
    assign memPort.we     = dataBus.wr;
    assign memPort.byteEn = dataBus.wr ? dataBus.byteEn : 4'b0000;
    assign memPort.wrData = dataBus.wrData;

    // --------------------------------------------------
    // Read data and status
    // --------------------------------------------------

    // Same word fans out, the busy flag tells fetch whose it is
    assign dataBus.rdData = memPort.rdData;
    assign instBus.inst   = memPort.rdData;

    // No valid word without a fetch request
    assign instBus.busy = dataGrant | ~instBus.rd;

endmodule

// File: rtl/MemPortBus.sv
interface MemPortBus
    import Types::*;
();

    DataAddr   addr;    // Byte address, word index taken inside
    logic      we;      // Write at next rising edge
    ByteEnable byteEn;  // Lanes to write
    Data       wrData;
    Data       rdData;  // Combinational read

    modport master (
        output addr, we, byteEn, wrData,
        input  rdData);

    modport slave (
        input  addr, we, byteEn, wrData,
        output rdData);

endinterface

// File: rtl/StageIF.sv
module StageIF
    import Config::*, Types::*;
(
    input  logic    i_clock,
    input  logic    i_rstN,

    InstMemoryBus.master instBus,           // Fetch port towards the arbiter

    input  InstAddr i_pcNext,               // PC to fetch this cycle
    output logic    o_hazard,               // Fetch lost the port
    output Inst     o_inst,                 // IF/ID instruction
    output logic    o_instCompressed,       // IF/ID came from an RVC parcel
    output logic    o_instValid,            // IF/ID holds a real fetch
    output InstAddr o_pc);                  // IF/ID PC

    InstWord fetchWord;                     // Memory word, parcels or full
    Inst     expInst;
    logic    expCompressed;

    // --------------------------------------------------
    // Fetch request
    // --------------------------------------------------

    assign instBus.addr   = i_pcNext;
    assign instBus.rd     = 1'b1;           // Always fetching
    assign fetchWord.inst = instBus.inst;
    assign o_hazard       = instBus.busy;   // Data access holds the port

    generate
    if (RV_EXT_C) begin : genExpander
        InstExpander expander (
            .i_inst         (fetchWord),
            .i_upperHalf    (i_pcNext[1]),
            .o_inst         (expInst),
            .o_isCompressed (expCompressed));
    end
    else begin : genBypass
        assign expInst       = fetchWord.inst;
        assign expCompressed = 1'b0;
    end
    endgenerate

    // --------------------------------------------------
    // IF/ID register
    // --------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rstN)
            o_instValid <= 1'b0;
        else
            o_instValid <= !o_hazard;       // Bubble on hazard
    end

    // Payload holds its last value across a bubble
    always_ff @(posedge i_clock) begin
        if (!o_hazard) begin
            o_inst           <= expInst;
            o_instCompressed <= expCompressed;
            o_pc             <= i_pcNext;
        end
    end

endmodule

// File: rtl/Types.sv
package Types;

    import Config::*;

    // --------------------------------------------------
    // Addresses and words
    // --------------------------------------------------

    typedef logic [ADDR_WIDTH-1:0] InstAddr;  // Fetch byte address
    typedef logic [ADDR_WIDTH-1:0] DataAddr;  // Load/store byte address

    typedef logic [31:0] Inst;                // Full RV32 instruction
    typedef logic [31:0] Data;                // Data word
    typedef logic [3:0]  ByteEnable;          // One bit per byte lane

    // --------------------------------------------------
    // Fetched word seen two ways
    // --------------------------------------------------

    // Two 16-bit parcels, high parcel at pc offset 2
    typedef struct packed {
        logic [15:0] high;
        logic [15:0] low;
    } InstParcels;

    // Either one 32-bit instruction or two RVC parcels
    typedef union packed {
        Inst        inst;
        InstParcels parcels;
    } InstWord;

    // --------------------------------------------------
    // Access size of loads and stores
    // --------------------------------------------------

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } MemSize;

endpackage

// File: rtl/UnifiedMemory.sv
module UnifiedMemory
    import Config::*, Types::*;
(
    input  logic i_clock,
    MemPortBus.slave memPort);              // Single shared port

    Data memArray [MEM_WORDS];              // Contents undefined until written

    logic [MEM_INDEX_WIDTH-1:0] wordIndex;

    // Word index sits just above the byte offset
    assign wordIndex = memPort.addr[MEM_INDEX_WIDTH+1:2];

    // --------------------------------------------------
    // Read and write
    // --------------------------------------------------

    assign memPort.rdData = memArray[wordIndex];  // Combinational read

    always_ff @(posedge i_clock) begin
        if (memPort.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (memPort.byteEn[lane])
                    memArray[wordIndex][8*lane +: 8] <= memPort.wrData[8*lane +: 8];
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tbCoreMem -o simCoreMem
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed"
    exit $status
fi

./obj_dir/simCoreMem
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
fi
exit $status

// File: src.f
rtl/Config.sv
rtl/Types.sv
rtl/InstMemoryBus.sv
rtl/DataMemoryBus.sv
rtl/MemPortBus.sv
rtl/InstExpander.sv
rtl/StageIF.sv
rtl/DataAccessUnit.sv
rtl/MemArbiter.sv
rtl/UnifiedMemory.sv
rtl/CoreMemSubsystem.sv
tests/tbCoreMem.sv

// File: tests/tbCoreMem.sv
module tbCoreMem
    import Config::*, Types::*;
();

    localparam int PERIOD    = 20;
    localparam int NUM_FORMS = 13;              // Nine supported RVC forms plus four others
    // Cycles per test section summed for the watchdog
    localparam int TOTAL_OPS = 3 + MEM_WORDS + 48 + 96 + 32 + NUM_FORMS * 12 + 32 + 400 + 4;

    logic    clock;
    logic    rstN;
    InstAddr pcNext;
    logic    hazard;
    Inst     inst;
    logic    instCompressed;
    logic    instValid;
    InstAddr pc;
    logic    memValid;
    logic    memRd;
    logic    memWr;
    MemSize  memSize;
    logic    memUnsigned;
    DataAddr memAddr;
    Data     memWrData;
    Data     memRdData;
    logic    memRdValid;

    Data  shadow [MEM_WORDS];                   // Mirror of every store
    logic known  [MEM_WORDS];                   // Word fully written at least once

    CoreMemSubsystem UUT (
        .i_clock          (clock),
        .i_rstN           (rstN),
        .i_pcNext         (pcNext),
        .o_hazard         (hazard),
        .o_inst           (inst),
        .o_instCompressed (instCompressed),
        .o_instValid      (instValid),
        .o_pc             (pc),
        .i_memValid       (memValid),
        .i_memRdEnable    (memRd),
        .i_memWrEnable    (memWr),
        .i_memSize        (memSize),
        .i_memUnsigned    (memUnsigned),
        .i_memAddr        (memAddr),
        .i_memWrData      (memWrData),
        .o_memRdData      (memRdData),
        .o_memRdValid     (memRdValid));

    initial begin
        clock = 1'b0;
        forever #(PERIOD/2) clock = ~clock;
    end

    initial begin
        #(TOTAL_OPS * PERIOD * 4);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Data owns the port whenever it reads or writes
    function automatic logic portTaken(logic valid, logic rd, logic wr);
        return valid & (rd | wr);
    endfunction

    function automatic Data loadResult(DataAddr addr, MemSize size, logic uns);
        Data         w;
        logic [7:0]  b;
        logic [15:0] h;
        int          off;
        w   = shadow[addr[MEM_INDEX_WIDTH+1:2]];
        off = int'(addr[1:0]);
        b   = w[8*off +: 8];
        h   = addr[1] ? w[31:16] : w[15:0];
        case (size)
            BYTE:    return uns ? {24'b0, b} : {{24{b[7]}}, b};
            HALF:    return uns ? {16'b0, h} : {{16{h[15]}}, h};
            default: return w;
        endcase
    endfunction

    // RV32I equivalent of the parcel at the chosen half per the RVC tables
    function automatic Inst expandParcel(Data word, logic upper);
        logic [15:0] c;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rdc;
        logic [4:0]  rs1c;
        logic [11:0] imm;
        logic [6:0]  uimm;
        logic [20:0] jo;
        logic [12:0] bo;
        c = upper ? word[31:16] : word[15:0];
        if (c[1:0] == 2'b11)
            return word;                        // Full instruction passes through
        rd   = c[11:7];
        rs2  = c[6:2];
        rdc  = 5'd8 + {2'b00, c[4:2]};          // x8..x15
        rs1c = 5'd8 + {2'b00, c[9:7]};
        imm  = {{7{c[12]}}, c[6:2]};
        uimm = '0;
        uimm[5:3] = c[12:10];
        uimm[2]   = c[6];
        uimm[6]   = c[5];
        jo = '0;
        jo[11]    = c[12];
        jo[4]     = c[11];
        jo[9:8]   = c[10:9];
        jo[10]    = c[8];
        jo[6]     = c[7];
        jo[7]     = c[6];
        jo[3:1]   = c[5:3];
        jo[5]     = c[2];
        jo[20:12] = {9{c[12]}};                 // Sign extension
        bo = '0;
        bo[8]     = c[12];
        bo[4:3]   = c[11:10];
        bo[7:6]   = c[6:5];
        bo[2:1]   = c[4:3];
        bo[5]     = c[2];
        bo[12:9]  = {4{c[12]}};
        case ({c[15:13], c[1:0]})
            5'b010_00: return {5'b0, uimm, rs1c, 3'b010, rdc, 7'h03};     // lw
            5'b110_00: return {5'b0, uimm[6:5], rdc, rs1c, 3'b010, uimm[4:0], 7'h23};
            5'b000_01: return {imm, rd, 3'b000, rd, 7'h13};               // addi rd, rd
            5'b010_01: return {imm, 5'd0, 3'b000, rd, 7'h13};             // addi rd, x0
            5'b101_01: return {jo[20], jo[10:1], jo[11], jo[19:12], 5'd0, 7'h6f};
            5'b110_01: return {bo[12], bo[10:5], 5'd0, rs1c, 3'b000, bo[4:1], bo[11], 7'h63};
            5'b100_10: begin
                if (rs2 == 5'd0)
                    return '0;                  // Jump forms not supported
                if (c[12])
                    return {7'b0, rs2, rd, 3'b000, rd, 7'h33};            // add
                return {7'b0, rs2, 5'd0, 3'b000, rd, 7'h33};              // mv
            end
            default:   return '0;
        endcase
    endfunction

    // Lane writes of one store into the mirror
    task automatic updateShadow(DataAddr addr, MemSize size, Data wdata);
        int idx;
        idx = int'(addr[MEM_INDEX_WIDTH+1:2]);
        for (int lane = 0; lane < 4; lane++) begin
            case (size)
                BYTE: if (lane == int'(addr[1:0]))
                    shadow[idx][8*lane +: 8] = wdata[7:0];
                HALF: if ((lane / 2) == int'(addr[1]))
                    shadow[idx][8*lane +: 8] = (lane % 2) ? wdata[15:8] : wdata[7:0];
                default:
                    shadow[idx][8*lane +: 8] = wdata[8*lane +: 8];
            endcase
        end
        if (size == WORD)
            known[idx] = 1'b1;
    endtask

    task automatic check(string name, logic [31:0] expVal, logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("Error at time %0t: %s expected %h, got %h", $time, name, expVal, actVal);
            $display("Verification failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // --------------------------------------------------
    // Compare process
    // --------------------------------------------------

    initial begin : compare
        logic    expHaz;
        logic    expValid;
        logic    expComp;
        logic    payloadKnown;
        Inst     expInst;
        InstAddr expPc;
        logic    expRdValid;
        Data     expRd;
        Data     word;
        logic [15:0] parcel;
        Inst     heldInst;                      // Payload last loaded into IF/ID
        logic    heldKnown;
        expValid   = 1'b0;
        expRdValid = 1'b0;
        heldKnown  = 1'b0;
        forever begin
            @(negedge clock);
            #5;                                 // Inputs settled
            expHaz = portTaken(memValid, memRd, memWr);
            check("o_hazard", 32'(expHaz), 32'(hazard));
            expValid     = rstN & ~expHaz;
            payloadKnown = known[pcNext[MEM_INDEX_WIDTH+1:2]];
            word         = shadow[pcNext[MEM_INDEX_WIDTH+1:2]];
            parcel       = pcNext[1] ? word[31:16] : word[15:0];
            expInst      = RV_EXT_C ? expandParcel(word, pcNext[1]) : word;
            expComp      = RV_EXT_C & (parcel[1:0] != 2'b11);
            expPc        = pcNext;
            expRdValid   = rstN & memValid & memRd;
            if (expRdValid)
                expRd = loadResult(memAddr, memSize, memUnsigned);
            if (memValid && memWr)
                updateShadow(memAddr, memSize, memWrData);  // Lands at this edge
            @(posedge clock);
            #5;                                 // Registers updated
            check("o_instValid", 32'(expValid), 32'(instValid));
            if (expValid && payloadKnown) begin
                check("o_inst", expInst, inst);
                check("o_instCompressed", 32'(expComp), 32'(instCompressed));
                check("o_pc", expPc, pc);
            end
            if (expHaz && heldKnown)
                check("o_inst", heldInst, inst);    // Bubble keeps the last payload
            if (!expHaz) begin
                heldInst  = expInst;
                heldKnown = payloadKnown;
            end
            check("o_memRdValid", 32'(expRdValid), 32'(memRdValid));
            if (expRdValid)
                check("o_memRdData", expRd, memRdData);
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    task automatic drive(InstAddr pcN, logic rd, logic wr, MemSize size, logic uns,
                         DataAddr addr, Data wdata);
        @(negedge clock);
        pcNext      = pcN;
        memValid    = rd | wr;
        memRd       = rd;
        memWr       = wr;
        memSize     = size;
        memUnsigned = uns;
        memAddr     = addr;
        memWrData   = wdata;
    endtask

    function automatic DataAddr dataAddrFor(MemSize size);
        DataAddr a;
        a = $urandom & 32'h3ff;                 // Inside the 1 KiB memory
        if (size == HALF)
            a[0] = 1'b0;
        if (size == WORD)
            a[1:0] = 2'b00;
        return a;
    endfunction

    function automatic InstAddr fetchPc();
        return ($urandom_range(MEM_WORDS-1, 0) << 2) | ($urandom_range(1, 0) << 1);
    endfunction

    // Random parcel of one RVC form with its opcode bits forced
    function automatic logic [15:0] makeParcel(int form);
        logic [15:0] p;
        p = 16'($urandom);
        case (form)
            0:  {p[15:13], p[1:0]} = 5'b010_00;     // C.LW
            1:  {p[15:13], p[1:0]} = 5'b110_00;     // C.SW
            2:  {p[15:13], p[1:0]} = 5'b000_01;     // C.ADDI
            3:  {p[15:13], p[1:0]} = 5'b010_01;     // C.LI
            4:  {p[15:13], p[1:0]} = 5'b101_01;     // C.J
            5:  {p[15:13], p[1:0]} = 5'b110_01;     // C.BEQZ
            6, 7: begin                             // C.MV and C.ADD
                {p[15:13], p[1:0]} = 5'b100_10;
                p[12] = (form == 7);
                if (p[6:2] == 5'd0)
                    p[2] = 1'b1;
            end
            8:  p = 16'h0001;                       // C.NOP
            9:  {p[15:13], p[1:0]} = 5'b000_00;     // Unsupported C.ADDI4SPN
            10: {p[15:13], p[1:0]} = 5'b011_01;     // Unsupported C.LUI
            11: begin                               // Unsupported C.JR
                {p[15:13], p[12], p[6:2], p[1:0]} = 11'b100_0_00000_10;
            end
            default: {p[15:13], p[1:0]} = 5'b001_00;  // Unsupported C.FLD
        endcase
        return p;
    endfunction

    initial begin : stimulus
        DataAddr     a;
        InstAddr     pcN;
        MemSize      size;
        int          op;
        void'($urandom(32'h2901));
        for (int i = 0; i < MEM_WORDS; i++)
            known[i] = 1'b0;
        pcNext      = '0;
        memValid    = 1'b0;
        memRd       = 1'b0;
        memWr       = 1'b0;
        memSize     = WORD;
        memUnsigned = 1'b0;
        memAddr     = '0;
        memWrData   = '0;
        rstN = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rstN = 1'b1;
        #5;
        check("o_instValid", 32'd0, 32'(instValid));          // Clean after reset
        check("o_memRdValid", 32'd0, 32'(memRdValid));

        // Fill every word with a pattern spread over all address bits
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = DataAddr'(i * 4);
            drive('0, 1'b0, 1'b1, WORD, 1'b0, a, (a * 32'h9e3779b1) ^ {a[15:0], ~a[15:0]});
        end

        // Stores of every size followed by loads of every size and sign
        for (int i = 0; i < 48; i++) begin
            size = MemSize'($urandom_range(2, 0));
            drive(fetchPc(), 1'b0, 1'b1, size, 1'b0, dataAddrFor(size), $urandom);
        end
        for (int i = 0; i < 96; i++) begin
            size = MemSize'($urandom_range(2, 0));
            drive(fetchPc(), 1'b1, 1'b0, size, 1'($urandom), dataAddrFor(size), '0);
        end

        // 32-bit instructions at word addresses
        for (int i = 0; i < 16; i++) begin
            a = dataAddrFor(WORD);
            drive('0, 1'b0, 1'b1, WORD, 1'b0, a, $urandom | 32'h3);
            drive(a, 1'b0, 1'b0, WORD, 1'b0, '0, '0);
        end

        // RVC forms in both halves fetched at offsets 0 and 2
        for (int form = 0; form < NUM_FORMS; form++) begin
            repeat (4) begin
                a = dataAddrFor(WORD);
                drive('0, 1'b0, 1'b1, WORD, 1'b0, a, {makeParcel(form), makeParcel(form)});
                drive(a, 1'b0, 1'b0, WORD, 1'b0, '0, '0);
                drive(a | 32'h2, 1'b0, 1'b0, WORD, 1'b0, '0, '0);
            end
        end

        // Fetch colliding with a data access and then retried
        for (int i = 0; i < 16; i++) begin
            pcN  = fetchPc();
            size = MemSize'($urandom_range(2, 0));
            if (i % 2)
                drive(pcN, 1'b1, 1'b0, size, 1'($urandom), dataAddrFor(size), '0);
            else
                drive(pcN, 1'b0, 1'b1, size, 1'b0, dataAddrFor(size), $urandom);
            drive(pcN, 1'b0, 1'b0, WORD, 1'b0, '0, '0);
        end

        // Random mix with one operation per cycle
        for (int i = 0; i < 400; i++) begin
            op   = $urandom_range(2, 0);
            size = MemSize'($urandom_range(2, 0));
            drive(fetchPc(), op == 1, op == 2, size, 1'($urandom), dataAddrFor(size), $urandom);
            memValid = ($urandom_range(3, 0) != 0);   // Enables now and then without valid
        end

        repeat (4) drive('0, 1'b0, 1'b0, WORD, 1'b0, '0, '0);   // Drain last checks
        @(negedge clock);
        $display("Verification passed");
        $finish;
    end

endmodule
